//--- Bender.yml
package:
  name: ahb_output_stage

sources:
  - files:
      - source/ahb_op_pkg.sv
      - source/op_arbiter.sv
      - source/op_addr_mux.sv
      - source/op_data_phase.sv
      - source/ahb_output_stage.sv
  - target: test
    files:
      - dv/output_stage_checker.sv
      - dv/tb_output_stage.sv

//--- dv/output_stage_checker.sv
// --------------------------------------
// Reference model of grant, lock and data phase, compared on every
// rising edge. Sets o_error on the first mismatch
// --------------------------------------

module output_stage_checker
  import ahb_op_pkg::*;
#(
  parameter int NUM_PORTS = 3                       // Input stages, up to 8
)
(
  input  logic                        HCLK,         // AHB clock
  input  logic                        HRESETn,      // Sync reset, active low
  input  ahb_ctrl_t [NUM_PORTS-1:0]   i_port_ctrl,  // Stimulus control
  input  logic      [NUM_PORTS-1:0]   i_held_tran,  // Stimulus held transfers
  input  hdata_t    [NUM_PORTS-1:0]   i_port_wdata, // Stimulus write data
  input  logic                        i_hreadyoutm, // Slave HREADYOUT
  input  ahb_ctrl_t                   i_ctrl,       // DUT o_ctrl
  input  logic      [NUM_PORTS-1:0]   i_active,     // DUT o_active
  input  hdata_t                      i_hwdatam,    // DUT o_hwdatam
  input  logic                        i_hreadymuxm, // DUT o_hreadymuxm
  output logic                        o_error       // Mismatch seen
);

  timeunit 1ns;
  timeprecision 1ps;

  port_idx_t            ref_grant;      // Model grant
  logic                 ref_none;       // Model no-grant
  logic                 ref_lock;       // Model lock flag
  port_idx_t            ref_dport;      // Model data port
  logic                 ref_ssel;       // Model slave selected
  ahb_ctrl_t            exp_ctrl;
  logic [NUM_PORTS-1:0] exp_active;
  logic                 exp_ready;
  hdata_t               exp_wdata;
  logic                 keep;           // Grant frozen by burst or lock
  int                   winner;         // -1 when nobody requests

  initial o_error = 1'b0;

  function automatic int lowest_requester(input ahb_ctrl_t [NUM_PORTS-1:0] ctrl,
                                          input logic [NUM_PORTS-1:0] held);
    int found;
    found = -1;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (found < 0 && held[p] && ctrl[p].sel)
        found = p;                      // First hit has top priority
    end
    return found;
  endfunction

  task automatic flag_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
    o_error = 1'b1;
  endtask

  // --------------------------------------
  // Expected outputs
  // --------------------------------------
  always_comb
  begin
    exp_ctrl   = ref_none ? '0 : i_port_ctrl[ref_grant];
    exp_active = ref_none ? '0 : (NUM_PORTS'(1) << ref_grant);
    exp_ready  = !ref_ssel || i_hreadyoutm;       // Wait states only when selected
    exp_wdata  = i_port_wdata[ref_dport];
    keep       = (exp_ctrl.mastlock && (ref_lock || exp_ctrl.sel)) ||
                 (exp_ctrl.sel && (exp_ctrl.trans inside {BUSY, SEQ}));
    winner     = lowest_requester(i_port_ctrl, i_held_tran);
  end

  always @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      ref_grant <= '0;
      ref_none  <= 1'b1;
      ref_lock  <= 1'b0;
      ref_dport <= '0;
      ref_ssel  <= 1'b0;
    end
    else if (exp_ready)
    begin
      if (exp_ctrl.sel && exp_ctrl.mastlock &&
          (exp_ctrl.trans == NONSEQ || exp_ctrl.trans == SEQ))
        ref_lock <= 1'b1;
      else if (!exp_ctrl.mastlock)
        ref_lock <= 1'b0;
      if (!keep)
      begin
        ref_none <= (winner < 0);
        if (winner >= 0)
          ref_grant <= port_idx_t'(winner);   // Index kept when idle
      end
      ref_dport <= ref_grant;
      ref_ssel  <= exp_ctrl.sel;
    end
  end

  // --------------------------------------
  // Checks
  // --------------------------------------
  a_reset_active: assert property (@(posedge HCLK) !HRESETn |=> i_active == '0)
    else flag_mismatch("o_active", $sampled(i_active), 0);
  a_reset_ready: assert property (@(posedge HCLK) !HRESETn |=> i_hreadymuxm)
    else flag_mismatch("o_hreadymuxm", $sampled(i_hreadymuxm), 1);
  a_reset_ctrl: assert property (@(posedge HCLK)
      !HRESETn |=> (!i_ctrl.sel && i_ctrl.trans == IDLE))
    else flag_mismatch("{o_ctrl.sel, o_ctrl.trans}", $sampled({i_ctrl.sel, i_ctrl.trans}), 0);
  a_ctrl: assert property (@(posedge HCLK) disable iff (!HRESETn) i_ctrl == exp_ctrl)
    else flag_mismatch("o_ctrl", $sampled(i_ctrl), $sampled(exp_ctrl));
  a_active: assert property (@(posedge HCLK) disable iff (!HRESETn) i_active == exp_active)
    else flag_mismatch("o_active", $sampled(i_active), $sampled(exp_active));
  a_ready: assert property (@(posedge HCLK) disable iff (!HRESETn) i_hreadymuxm == exp_ready)
    else flag_mismatch("o_hreadymuxm", $sampled(i_hreadymuxm), $sampled(exp_ready));
  a_wdata: assert property (@(posedge HCLK) disable iff (!HRESETn)
      ref_ssel |-> i_hwdatam == exp_wdata)
    else flag_mismatch("o_hwdatam", $sampled(i_hwdatam), $sampled(exp_wdata));

endmodule

//--- dv/tb_output_stage.sv
// --------------------------------------
// Three ports with stimulus on falling edges
// The checker instance does all checking
// --------------------------------------

module tb_output_stage
  import ahb_op_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_PORTS  = 3;
  localparam int WAIT_LIMIT = 20;                 // Cycles per wait

  logic                      HCLK;
  logic                      HRESETn;
  ahb_ctrl_t [NUM_PORTS-1:0] port_ctrl;
  logic      [NUM_PORTS-1:0] held_tran;
  hdata_t    [NUM_PORTS-1:0] port_wdata;
  logic                      hreadyoutm;
  ahb_ctrl_t                 ctrl;
  logic      [NUM_PORTS-1:0] active;
  hdata_t                    hwdatam;
  logic                      hreadymuxm;
  logic                      chk_error;           // From checker
  integer                    seed;

  ahb_output_stage #(.NUM_PORTS(NUM_PORTS)) u_dut
  (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_ctrl  (port_ctrl),
    .i_held_tran  (held_tran),
    .i_port_wdata (port_wdata),
    .i_hreadyoutm (hreadyoutm),
    .o_ctrl       (ctrl),
    .o_active     (active),
    .o_hwdatam    (hwdatam),
    .o_hreadymuxm (hreadymuxm)
  );

  output_stage_checker #(.NUM_PORTS(NUM_PORTS)) u_checker
  (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_ctrl  (port_ctrl),
    .i_held_tran  (held_tran),
    .i_port_wdata (port_wdata),
    .i_hreadyoutm (hreadyoutm),
    .i_ctrl       (ctrl),
    .i_active     (active),
    .i_hwdatam    (hwdatam),
    .i_hreadymuxm (hreadymuxm),
    .o_error      (chk_error)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;                     // 20 ns period
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Simulation stopped");
  endtask

  always @(posedge chk_error)
    stop_with_failure("Checker reported a mismatch");

  // New random write data every cycle
  task automatic next_cycle();
    @(negedge HCLK);
    for (int p = 0; p < NUM_PORTS; p++)
      port_wdata[p] = $random(seed);
  endtask

  task automatic set_port(input int p, input logic sel, input htrans_e trans,
                          input logic lock);
    port_ctrl[p].sel      = sel;
    port_ctrl[p].addr     = $random(seed);
    port_ctrl[p].trans    = trans;
    port_ctrl[p].write    = 1'b1;
    port_ctrl[p].size     = 3'd2;                 // Word
    port_ctrl[p].burst    = 3'd1;                 // INCR
    port_ctrl[p].prot     = 4'h3;
    port_ctrl[p].master   = 4'(p);
    port_ctrl[p].mastlock = lock;
    held_tran[p]          = sel;
  endtask

  task automatic wait_grant(input int p);
    int n;
    n = 0;
    while (active !== (NUM_PORTS'(1) << p) && n < WAIT_LIMIT)
    begin
      next_cycle();
      n++;
    end
    if (n >= WAIT_LIMIT)
      stop_with_failure($sformatf("Timed out waiting for port %0d to be granted", p));
  endtask

  initial
  begin
    seed       = 51;
    HRESETn    = 1'b0;
    port_ctrl  = '0;
    held_tran  = '0;
    port_wdata = '0;
    hreadyoutm = 1'b1;
    repeat (2) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
    // ---------------------------------------
    next_cycle();                                 // Single request
    set_port(1, 1'b1, NONSEQ, 1'b0);
    wait_grant(1);
    next_cycle();
    set_port(1, 1'b0, IDLE, 1'b0);
    next_cycle();                                 // Port 1 wins the collision
    set_port(1, 1'b1, NONSEQ, 1'b0);
    set_port(2, 1'b1, NONSEQ, 1'b0);
    wait_grant(1);
    next_cycle();
    set_port(1, 1'b1, SEQ, 1'b0);                 // Burst holds against port 0
    set_port(0, 1'b1, NONSEQ, 1'b0);
    next_cycle();
    set_port(1, 1'b1, BUSY, 1'b0);
    next_cycle();
    set_port(1, 1'b1, SEQ, 1'b0);
    next_cycle();
    set_port(1, 1'b0, IDLE, 1'b0);
    wait_grant(0);
    // ---------------------------------------
    next_cycle();                                 // Last beat of port 0 passes on
    held_tran[0] = 1'b0;                          // Select alone is no request
    next_cycle();                                 // Port 2 in address phase
    hreadyoutm = 1'b0;                            // Port 0 data phase waits
    set_port(0, 1'b1, NONSEQ, 1'b0);              // New request must not win yet
    repeat (3) next_cycle();
    hreadyoutm = 1'b1;
    wait_grant(0);
    next_cycle();
    set_port(0, 1'b0, IDLE, 1'b0);
    wait_grant(2);
    next_cycle();                                 // Locked sequence from port 2
    set_port(2, 1'b0, IDLE, 1'b0);
    next_cycle();
    set_port(2, 1'b1, NONSEQ, 1'b1);
    wait_grant(2);
    next_cycle();
    set_port(2, 1'b1, SEQ, 1'b1);
    set_port(0, 1'b1, NONSEQ, 1'b0);
    next_cycle();
    set_port(2, 1'b0, IDLE, 1'b1);                // Lock outlives the select
    repeat (2) next_cycle();
    set_port(2, 1'b0, IDLE, 1'b0);
    wait_grant(0);
    next_cycle();
    set_port(0, 1'b0, IDLE, 1'b0);
    repeat (3) next_cycle();
    if (chk_error)
      stop_with_failure("Checker flagged an error");
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

//--- source/ahb_op_pkg.sv
// --------------------------------------
// AHB types for the output stage. Port index is 3 bits, max 8 ports
// User sideband buses are not carried
// --------------------------------------

package ahb_op_pkg;

  // --------------------------------------
  // Field widths
  // --------------------------------------
  parameter int PORT_IDX_W = 3;             // Port index width

  typedef logic [PORT_IDX_W-1:0] port_idx_t; // Input port number
  typedef logic [31:0]           haddr_t;    // HADDR
  typedef logic [31:0]           hdata_t;    // HWDATA
  typedef logic [2:0]            hsize_t;    // HSIZE
  typedef logic [2:0]            hburst_t;   // HBURST
  typedef logic [3:0]            hprot_t;    // HPROT
  typedef logic [3:0]            hmaster_t;  // HMASTER

  // HTRANS encoding, bit 1 marks an active transfer
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,                         // No transfer
    BUSY   = 2'b01,                         // Burst paused
    NONSEQ = 2'b10,                         // First beat
    SEQ    = 2'b11                          // Following beats
  } htrans_e;

  // --------------------------------------
  // Address-phase control of one port
  // --------------------------------------
  typedef struct packed
  {
    logic     sel;                          // HSEL
    haddr_t   addr;                         // HADDR
    htrans_e  trans;                        // HTRANS
    logic     write;                        // HWRITE
    hsize_t   size;                         // HSIZE
    hburst_t  burst;                        // HBURST
    hprot_t   prot;                         // HPROT
    hmaster_t master;                       // HMASTER
    logic     mastlock;                     // HMASTLOCK
  } ahb_ctrl_t;                             // 51 bits

endpackage

//--- source/ahb_output_stage.sv
// --------------------------------------
// Output stage for one shared slave, ports 0 to NUM_PORTS-1
// NUM_PORTS must not exceed 8
// --------------------------------------

module ahb_output_stage
  import ahb_op_pkg::*;
#(
  parameter int NUM_PORTS = 3                       // Input stages, up to 8
)
(
  input  logic                        HCLK,         // AHB clock
  input  logic                        HRESETn,      // Sync reset, active low
  input  ahb_ctrl_t [NUM_PORTS-1:0]   i_port_ctrl,  // From input stages
  input  logic      [NUM_PORTS-1:0]   i_held_tran,  // Pending transfers
  input  hdata_t    [NUM_PORTS-1:0]   i_port_wdata, // Write data per port
  input  logic                        i_hreadyoutm, // Slave HREADYOUT
  output ahb_ctrl_t                   o_ctrl,       // Address/control to slave
  output logic      [NUM_PORTS-1:0]   o_active,     // Active port, one-hot
  output hdata_t                      o_hwdatam,    // HWDATA to slave
  output logic                        o_hreadymuxm  // HREADY to slave
);

  // --------------------------------------
  // Internal wiring
  // --------------------------------------
  port_idx_t grant_port;                // Registered grant
  logic      no_port;                   // No port granted
  ahb_ctrl_t muxed_ctrl;                // Granted port control
  logic      hready_mux;                // Phase completion

  op_arbiter #(.NUM_PORTS(NUM_PORTS)) u_arbiter
  (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_ctrl  (i_port_ctrl),
    .i_held_tran  (i_held_tran),
    .i_muxed_ctrl (muxed_ctrl),         // Burst and lock feedback
    .i_hready     (hready_mux),
    .o_grant_port (grant_port),
    .o_no_port    (no_port)
  );

  op_addr_mux #(.NUM_PORTS(NUM_PORTS)) u_addr_mux
  (
    .i_port_ctrl  (i_port_ctrl),
    .i_grant_port (grant_port),
    .i_no_port    (no_port),
    .o_ctrl       (muxed_ctrl),
    .o_active     (o_active)
  );

  op_data_phase #(.NUM_PORTS(NUM_PORTS)) u_data_phase
  (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_grant_port (grant_port),
    .i_sel        (muxed_ctrl.sel),
    .i_port_wdata (i_port_wdata),
    .i_hreadyoutm (i_hreadyoutm),
    .o_hwdata     (o_hwdatam),
    .o_hready     (hready_mux)
  );

  assign o_ctrl       = muxed_ctrl;
  assign o_hreadymuxm = hready_mux;

endmodule

//--- source/op_addr_mux.sv
// --------------------------------------
// Purely combinational. Output is all zeros with no grant
// --------------------------------------

module op_addr_mux
  import ahb_op_pkg::*;
#(
  parameter int NUM_PORTS = 3                       // Input stages, up to 8
)
(
  input  ahb_ctrl_t [NUM_PORTS-1:0]   i_port_ctrl,  // Per-port address/control
  input  port_idx_t                   i_grant_port, // Granted port
  input  logic                        i_no_port,    // Nothing granted
  output ahb_ctrl_t                   o_ctrl,       // Control to slave
  output logic      [NUM_PORTS-1:0]   o_active      // One-hot active port
);

  // --------------------------------------
  // Address/control select
  // --------------------------------------
  always_comb
  begin
    o_ctrl = '0;                          // IDLE, sel low
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (!i_no_port && (i_grant_port == port_idx_t'(p)))
      begin
        o_ctrl = i_port_ctrl[p];          // Whole struct passes through
      end
    end
  end

  // --------------------------------------
  // Active decode
  // --------------------------------------
  always_comb
  begin
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      // Index out of range decodes to nothing
      o_active[p] = !i_no_port && (i_grant_port == port_idx_t'(p));
    end
  end

endmodule

//--- source/op_arbiter.sv
// --------------------------------------
// Fixed priority, port 0 highest. Grant is held during bursts
// and locked sequences, and moves only on HREADY edges
// --------------------------------------

module op_arbiter
  import ahb_op_pkg::*;
#(
  parameter int NUM_PORTS = 3                       // Input stages, up to 8
)
(
  input  logic                        HCLK,         // AHB clock
  input  logic                        HRESETn,      // Sync reset, active low
  input  ahb_ctrl_t [NUM_PORTS-1:0]   i_port_ctrl,  // Per-port address/control
  input  logic      [NUM_PORTS-1:0]   i_held_tran,  // Pending transfer per port
  input  ahb_ctrl_t                   i_muxed_ctrl, // Control of granted port
  input  logic                        i_hready,     // Phase done
  output port_idx_t                   o_grant_port, // Registered grant
  output logic                        o_no_port     // Nothing granted
);

  // --------------------------------------
  // Requests and hold terms
  // --------------------------------------
  logic [NUM_PORTS-1:0] req;              // Per-port request
  logic                 hsel_lock;        // Locked sequence in progress
  logic                 next_hsel_lock;   // Next lock flag
  logic                 hlock_arb;        // Lock masked by select
  logic                 burst_hold;       // Burst still running
  logic                 hold_grant;       // Keep current grant
  port_idx_t            grant_port;       // Grant register
  logic                 no_port;          // No-grant register
  port_idx_t            next_grant;       // Grant to load
  logic                 next_no_port;     // No-grant to load

  always_comb
  begin
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      req[p] = i_held_tran[p] & i_port_ctrl[p].sel;   // Held transfer aimed here
    end
  end

  // Lock survives a select drop mid-sequence until HMASTLOCK falls
  always_comb
  begin
    if (i_muxed_ctrl.sel && i_muxed_ctrl.trans[1] && i_muxed_ctrl.mastlock)
      next_hsel_lock = 1'b1;              // Locked active transfer seen
    else if (!i_muxed_ctrl.mastlock)
      next_hsel_lock = 1'b0;              // Lock released
    else
      next_hsel_lock = hsel_lock;
  end

  assign hlock_arb  = i_muxed_ctrl.mastlock & (hsel_lock | i_muxed_ctrl.sel);
  assign burst_hold = i_muxed_ctrl.sel &
                      ((i_muxed_ctrl.trans == BUSY) || (i_muxed_ctrl.trans == SEQ));
  assign hold_grant = hlock_arb | burst_hold;

  // --------------------------------------
  // Next grant
  // --------------------------------------
  always_comb
  begin
    next_grant   = grant_port;            // Index kept when idle
    next_no_port = 1'b1;
    if (hold_grant)
    begin
      next_no_port = no_port;             // Stay on current port
    end
    else
    begin
      // Walk down so the lowest index wins
      for (int p = NUM_PORTS - 1; p >= 0; p--)
      begin
        if (req[p])
        begin
          next_grant   = port_idx_t'(p);
          next_no_port = 1'b0;
        end
      end
    end
  end

  // --------------------------------------
  // Registers, HREADY edges only
  // --------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      hsel_lock  <= 1'b0;
      grant_port <= '0;
      no_port    <= 1'b1;                 // Idle out of reset
    end
    else if (i_hready)
    begin
      hsel_lock  <= next_hsel_lock;
      grant_port <= next_grant;
      no_port    <= next_no_port;
    end
  end

  assign o_grant_port = grant_port;
  assign o_no_port    = no_port;

endmodule

//--- source/op_data_phase.sv
// --------------------------------------
// Data phase follows the address phase by one HREADY edge
// Wait states from the slave stall every register
// --------------------------------------

module op_data_phase
  import ahb_op_pkg::*;
#(
  parameter int NUM_PORTS = 3                       // Input stages, up to 8
)
(
  input  logic                        HCLK,         // AHB clock
  input  logic                        HRESETn,      // Sync reset, active low
  input  port_idx_t                   i_grant_port, // Address-phase port
  input  logic                        i_sel,        // Muxed HSEL
  input  hdata_t    [NUM_PORTS-1:0]   i_port_wdata, // Per-port write data
  input  logic                        i_hreadyoutm, // Slave HREADYOUT
  output hdata_t                      o_hwdata,     // Write data to slave
  output logic                        o_hready      // HREADYMUX
);

  port_idx_t data_port;                 // Port owning the data phase
  logic      slave_sel;                 // Slave selected in data phase
  logic      hready;                    // Internal HREADY

  // --------------------------------------
  // HREADY generation
  // --------------------------------------
  // Only a selected slave can insert wait states
  assign hready = slave_sel ? i_hreadyoutm : 1'b1;

  // --------------------------------------
  // Data-phase registers
  // --------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port <= '0;
      slave_sel <= 1'b0;                // Ready high after reset
    end
    else if (hready)
    begin
      data_port <= i_grant_port;        // Address phase moves to data
      slave_sel <= i_sel;
    end
  end

  // Write data mux
  always_comb
  begin
    o_hwdata = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (data_port == port_idx_t'(p))
        o_hwdata = i_port_wdata[p];
    end
  end

  assign o_hready = hready;

endmodule

//--- verilog.f
source/ahb_op_pkg.sv
source/op_arbiter.sv
source/op_addr_mux.sv
source/op_data_phase.sv
source/ahb_output_stage.sv
dv/output_stage_checker.sv
dv/tb_output_stage.sv
